// File: common/fdsu_pkg.sv
//========================================
// Shared types and constants for the
// divide/sqrt second execute stage
//========================================
`default_nettype none

package fdsu_pkg;

  //========================================
  // Widths
  //========================================
  // Exponent result, two's complement
  localparam int EXP_W  = 13;
  // Denormal rounding add number
  localparam int FRAC_W = 53;
  // Rounding mode
  localparam int RM_W   = 3;

  //========================================
  // Formats
  //========================================
  typedef enum logic [1:0] {
    FMT_DOUBLE = 2'd0,
    FMT_SINGLE = 2'd1,
    FMT_HALF   = 2'd2,
    FMT_BFLOAT = 2'd3
  } fp_fmt_t;

  //========================================
  // Per-format exponent limits
  //========================================
  // Index order: double, single, half, bfloat

  // Overflow above, potential overflow at
  localparam logic signed [EXP_W-1:0] EXP_OF_MAX [4] = '{
    13'sd1024, 13'sd128, 13'sd16, 13'sd128
  };

  // Underflow at or below
  localparam logic signed [EXP_W-1:0] EXP_UF_MAX [4] = '{
    -13'sd1023, -13'sd127, -13'sd15, -13'sd127
  };

  // Potential underflow, also the smallest normal exponent
  localparam logic signed [EXP_W-1:0] EXP_POTNT_UF [4] = '{
    -13'sd1022, -13'sd126, -13'sd14, -13'sd126
  };

  // Result too small for any rounding bit, skip the SRT loop
  localparam logic signed [EXP_W-1:0] EXP_SKIP_LT [4] = '{
    -13'sd1075, -13'sd150, -13'sd25, -13'sd150
  };

  // Add number bit position at EXP_POTNT_UF
  localparam logic [5:0] DENORM_BASE_BIT [4] = '{
    6'd0, 6'd29, 6'd42, 6'd45
  };

  //========================================
  // Stage structs
  //========================================
  // Operation as presented to stage two
  typedef struct packed {
    fp_fmt_t          fmt;
    logic             div;
    logic             sqrt;
    logic             op0_norm;
    logic             op1_norm;
    logic [EXP_W-1:0] expnt_add0;
    logic [EXP_W-1:0] expnt_add1;
    // Overflow rounds to largest finite number
    logic             of_rm_lfn;
    logic             result_zero;
    logic             result_qnan;
    logic             result_inf;
    logic             result_sign;
    logic             nv;
    logic             dz;
    logic [RM_W-1:0]  rm;
    // Special case already known in stage one
    logic             srt_skip;
  } fdsu_ex2_op_t;

  // Exponent evaluation results
  typedef struct packed {
    logic [EXP_W-1:0] expnt_rst;
    logic             of;
    logic             uf;
    logic             potnt_of;
    logic             potnt_uf;
    logic             id_srt_skip;
  } fdsu_expnt_flags_t;

  // Everything stage three needs
  typedef struct packed {
    fp_fmt_t           fmt;
    logic [EXP_W-1:0]  expnt_rst;
    logic              of;
    logic              uf;
    logic              potnt_of;
    logic              potnt_uf;
    logic              rslt_denorm;
    logic              id_srt_skip;
    logic              result_zero;
    logic              result_qnan;
    logic              result_inf;
    logic              result_lfn;
    logic              result_sign;
    logic              nv;
    logic              dz;
    logic [RM_W-1:0]   rm;
    logic [FRAC_W-1:0] denorm_round_add_num;
  } fdsu_ex3_info_t;

endpackage

`default_nettype wire

// File: design/fdsu_expnt_eval.sv
//========================================
// Exponent difference, range checks and
// SRT skip decision
//========================================
`default_nettype none

module fdsu_expnt_eval (
  input  fdsu_pkg::fdsu_ex2_op_t      op,
  output fdsu_pkg::fdsu_expnt_flags_t flags,
  output logic                        skip_srt
);

  import fdsu_pkg::*;

  logic [EXP_W-1:0]        expnt_diff;
  logic signed [EXP_W-1:0] expnt_rst;

  // Limits of the current format
  logic signed [EXP_W-1:0] of_max;
  logic signed [EXP_W-1:0] uf_max;
  logic signed [EXP_W-1:0] potnt_uf_lim;
  logic signed [EXP_W-1:0] skip_lim;

  // Raw compares, before operand gating
  logic expnt_of;
  logic expnt_uf;
  logic potnt_of_pre;
  logic potnt_uf_pre;
  logic id_srt_skip;

  logic div_norm;
  logic div_of;
  logic div_uf;
  logic div_potnt_of;
  logic potnt_uf;

  //========================================
  // Exponent result
  //========================================
  assign expnt_diff = op.expnt_add0 - op.expnt_add1;

  // Square root halves the difference, sign kept
  assign expnt_rst = op.sqrt ? {expnt_diff[EXP_W-1], expnt_diff[EXP_W-1:1]}
                             : expnt_diff;

  //========================================
  // Range checks
  //========================================
  assign of_max       = EXP_OF_MAX[op.fmt];
  assign uf_max       = EXP_UF_MAX[op.fmt];
  assign potnt_uf_lim = EXP_POTNT_UF[op.fmt];
  assign skip_lim     = EXP_SKIP_LT[op.fmt];

  assign expnt_of     = expnt_rst >  of_max;
  assign potnt_of_pre = expnt_rst == of_max;
  assign expnt_uf     = expnt_rst <= uf_max;
  assign potnt_uf_pre = expnt_rst == potnt_uf_lim;

  // Far below the denormal range, result is zero or min
  assign id_srt_skip  = expnt_rst <  skip_lim;

  //========================================
  // Operand gating
  //========================================
  // Only a divide of two normals can leave the range here
  assign div_norm     = op.div && op.op0_norm && op.op1_norm;

  assign div_of       = div_norm && expnt_of;
  assign div_uf       = div_norm && expnt_uf;
  assign div_potnt_of = div_norm && potnt_of_pre;

  // Sqrt also sees this one, so only op0 counts
  assign potnt_uf     = potnt_uf_pre && op.op0_norm;

  //========================================
  // Outputs
  //========================================
  assign flags.expnt_rst   = expnt_rst;
  assign flags.of          = div_of;
  assign flags.uf          = div_uf;
  assign flags.potnt_of    = div_potnt_of;
  assign flags.potnt_uf    = potnt_uf;
  assign flags.id_srt_skip = id_srt_skip;

  // No iteration needed when the result is already settled
  assign skip_srt = div_of || id_srt_skip || op.srt_skip;

endmodule

`default_nettype wire

// File: design/fdsu_denorm_round_num.sv
//========================================
// One-hot round add number for a
// denormal result
//========================================
`default_nettype none

module fdsu_denorm_round_num (
  input  logic [12:0]       expnt_rst,
  input  fdsu_pkg::fp_fmt_t fmt,
  output logic [52:0]       round_add_num
);

  import fdsu_pkg::*;

  logic signed [EXP_W-1:0] potnt_uf_lim;
  logic [5:0]              base_bit;
  logic [5:0]              span;
  logic signed [EXP_W:0]   offset;
  logic                    in_range;
  logic [5:0]              bit_idx;

  assign potnt_uf_lim = EXP_POTNT_UF[fmt];
  assign base_bit     = DENORM_BASE_BIT[fmt];

  // Number of positions left above the base bit
  assign span = 6'(FRAC_W - 1) - base_bit;

  // Distance below the smallest normal exponent, one extra bit
  // so the subtraction cannot wrap
  assign offset = {potnt_uf_lim[EXP_W-1], potnt_uf_lim}
                - {expnt_rst[EXP_W-1], expnt_rst};

  assign in_range = !offset[EXP_W]
                 && (offset[EXP_W-1:0] <= {{(EXP_W-6){1'b0}}, span});

  // Each step down moves the rounding point up one bit
  assign bit_idx = base_bit + offset[5:0];

  //========================================
  // Decode
  //========================================
  always_comb
  begin
    round_add_num = '0;
    if (in_range)
    begin
      round_add_num[bit_idx] = 1'b1;
    end
  end

endmodule

`default_nettype wire

// File: design/fdsu_ex3_pipe.sv
//========================================
// Inf/LFN result select and the
// stage three register
//========================================
`default_nettype none

module fdsu_ex3_pipe (
  input  logic                        ex2_pipe_clk,
  input  logic                        cpurst_b,
  input  logic                        ex2_pipedown,
  input  fdsu_pkg::fdsu_ex2_op_t      op,
  input  fdsu_pkg::fdsu_expnt_flags_t flags,
  input  logic [52:0]                 round_add_num,
  output fdsu_pkg::fdsu_ex3_info_t    ex3_info
);

  import fdsu_pkg::*;

  logic           result_inf;
  logic           result_lfn;
  fdsu_ex3_info_t ex3_nxt;

  //========================================
  // Special results
  //========================================
  // Overflow goes to inf or largest finite by rounding mode
  assign result_inf = op.result_inf || (flags.of && !op.of_rm_lfn);
  assign result_lfn = flags.of && op.of_rm_lfn;

  //========================================
  // Next stage three contents
  //========================================
  always_comb
  begin
    ex3_nxt.fmt                  = op.fmt;
    ex3_nxt.expnt_rst            = flags.expnt_rst;
    ex3_nxt.of                   = flags.of;
    ex3_nxt.uf                   = flags.uf;
    ex3_nxt.potnt_of             = flags.potnt_of;
    ex3_nxt.potnt_uf             = flags.potnt_uf;
    // Underflowed result is denormal before rounding
    ex3_nxt.rslt_denorm          = flags.uf;
    ex3_nxt.id_srt_skip          = flags.id_srt_skip;
    ex3_nxt.result_zero          = op.result_zero;
    ex3_nxt.result_qnan          = op.result_qnan;
    ex3_nxt.result_inf           = result_inf;
    ex3_nxt.result_lfn           = result_lfn;
    ex3_nxt.result_sign          = op.result_sign;
    ex3_nxt.nv                   = op.nv;
    ex3_nxt.dz                   = op.dz;
    ex3_nxt.rm                   = op.rm;
    ex3_nxt.denorm_round_add_num = round_add_num;
  end

  //========================================
  // Stage register, holds while pipedown low
  //========================================
  always_ff @(posedge ex2_pipe_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
    begin
      ex3_info     <= '0;
      ex3_info.fmt <= FMT_DOUBLE;
    end
    else if (ex2_pipedown)
    begin
      ex3_info <= ex3_nxt;
    end
  end

endmodule

`default_nettype wire

// File: design/fdsu_ex2_stage.sv
//========================================
// Divide/sqrt second execute stage top
//========================================
`default_nettype none

module fdsu_ex2_stage (
  input  logic                     ex2_pipe_clk,
  input  logic                     cpurst_b,
  input  logic                     ex2_pipedown,
  input  fdsu_pkg::fdsu_ex2_op_t   ex2_op,
  output logic                     srt_ctrl_skip_srt,
  output fdsu_pkg::fdsu_ex3_info_t ex3_info
);

  import fdsu_pkg::*;

  fdsu_expnt_flags_t expnt_flags;
  logic [FRAC_W-1:0] round_add_num;

  //========================================
  // Exponent evaluation
  //========================================
  fdsu_expnt_eval u_expnt_eval (
    .op       (ex2_op),
    .flags    (expnt_flags),
    .skip_srt (srt_ctrl_skip_srt)
  );

  //========================================
  // Denormal rounding prep
  //========================================
  fdsu_denorm_round_num u_denorm_round_num (
    .expnt_rst     (expnt_flags.expnt_rst),
    .fmt           (ex2_op.fmt),
    .round_add_num (round_add_num)
  );

  //========================================
  // Pipe to stage three
  //========================================
  fdsu_ex3_pipe u_ex3_pipe (
    .ex2_pipe_clk  (ex2_pipe_clk),
    .cpurst_b      (cpurst_b),
    .ex2_pipedown  (ex2_pipedown),
    .op            (ex2_op),
    .flags         (expnt_flags),
    .round_add_num (round_add_num),
    .ex3_info      (ex3_info)
  );

endmodule

`default_nettype wire

// File: sim/tb_fdsu_cases.svh
//========================================
// Case table for the stage two testbench
//========================================
`ifndef TB_FDSU_CASES_SVH
`define TB_FDSU_CASES_SVH

// Columns: fmt, {div,sqrt,op0_norm,op1_norm}, add0, add1,
//   {of_rm_lfn,srt_skip,pipedown}, skip, expnt_rst,
//   {of,uf,potnt_of,potnt_uf,id_srt_skip}, {inf,lfn}, add num bit or -1
task automatic load_cases();
  // Overflow, potential overflow, op1 not normal
  add_case(FMT_DOUBLE, 4'b1011, 1100, 75, 3'b001, 1'b1, 1025, 5'b10000, 2'b10, -1);
  add_case(FMT_DOUBLE, 4'b1011, 1100, 75, 3'b101, 1'b1, 1025, 5'b10000, 2'b01, -1);
  add_case(FMT_DOUBLE, 4'b1011, 1024, 0, 3'b001, 1'b0, 1024, 5'b00100, 2'b00, -1);
  add_case(FMT_DOUBLE, 4'b1010, 1100, 75, 3'b001, 1'b0, 1025, 5'b00000, 2'b00, -1);
  add_case(FMT_SINGLE, 4'b1011, 200, 71, 3'b001, 1'b1, 129, 5'b10000, 2'b10, -1);
  add_case(FMT_SINGLE, 4'b1011, 200, 71, 3'b101, 1'b1, 129, 5'b10000, 2'b01, -1);
  add_case(FMT_SINGLE, 4'b1011, 128, 0, 3'b001, 1'b0, 128, 5'b00100, 2'b00, -1);
  add_case(FMT_SINGLE, 4'b1010, 200, 71, 3'b001, 1'b0, 129, 5'b00000, 2'b00, -1);
  add_case(FMT_HALF, 4'b1011, 20, 3, 3'b001, 1'b1, 17, 5'b10000, 2'b10, -1);
  add_case(FMT_HALF, 4'b1011, 20, 3, 3'b101, 1'b1, 17, 5'b10000, 2'b01, -1);
  add_case(FMT_HALF, 4'b1011, 16, 0, 3'b001, 1'b0, 16, 5'b00100, 2'b00, -1);
  add_case(FMT_HALF, 4'b1010, 20, 3, 3'b001, 1'b0, 17, 5'b00000, 2'b00, -1);
  add_case(FMT_BFLOAT, 4'b1011, 200, 71, 3'b001, 1'b1, 129, 5'b10000, 2'b10, -1);
  add_case(FMT_BFLOAT, 4'b1011, 200, 71, 3'b101, 1'b1, 129, 5'b10000, 2'b01, -1);
  add_case(FMT_BFLOAT, 4'b1011, 128, 0, 3'b001, 1'b0, 128, 5'b00100, 2'b00, -1);
  add_case(FMT_BFLOAT, 4'b1010, 200, 71, 3'b001, 1'b0, 129, 5'b00000, 2'b00, -1);

  // Underflow, potential underflow, denormal range edges, skip region
  add_case(FMT_DOUBLE, 4'b1011, 0, 1023, 3'b001, 1'b0, -1023, 5'b01000, 2'b00, 1);
  add_case(FMT_DOUBLE, 4'b1011, 2, 1024, 3'b001, 1'b0, -1022, 5'b00010, 2'b00, 0);
  add_case(FMT_DOUBLE, 4'b1011, 0, 1074, 3'b001, 1'b0, -1074, 5'b01000, 2'b00, 52);
  add_case(FMT_DOUBLE, 4'b1011, 0, 1075, 3'b001, 1'b0, -1075, 5'b01000, 2'b00, -1);
  add_case(FMT_DOUBLE, 4'b1011, 0, 1076, 3'b001, 1'b1, -1076, 5'b01001, 2'b00, -1);
  add_case(FMT_DOUBLE, 4'b1001, 2, 1024, 3'b001, 1'b0, -1022, 5'b00000, 2'b00, 0);
  add_case(FMT_DOUBLE, 4'b1011, 5, 5, 3'b011, 1'b1, 0, 5'b00000, 2'b00, -1);
  add_case(FMT_SINGLE, 4'b1011, 0, 127, 3'b001, 1'b0, -127, 5'b01000, 2'b00, 30);
  add_case(FMT_SINGLE, 4'b1011, 0, 126, 3'b001, 1'b0, -126, 5'b00010, 2'b00, 29);
  add_case(FMT_SINGLE, 4'b1011, 0, 149, 3'b001, 1'b0, -149, 5'b01000, 2'b00, 52);
  add_case(FMT_SINGLE, 4'b1011, 0, 150, 3'b001, 1'b0, -150, 5'b01000, 2'b00, -1);
  add_case(FMT_SINGLE, 4'b1011, 0, 151, 3'b001, 1'b1, -151, 5'b01001, 2'b00, -1);
  add_case(FMT_HALF, 4'b1011, 0, 15, 3'b001, 1'b0, -15, 5'b01000, 2'b00, 43);
  add_case(FMT_HALF, 4'b1011, 0, 14, 3'b001, 1'b0, -14, 5'b00010, 2'b00, 42);
  add_case(FMT_HALF, 4'b1011, 0, 24, 3'b001, 1'b0, -24, 5'b01000, 2'b00, 52);
  add_case(FMT_HALF, 4'b1011, 0, 25, 3'b001, 1'b0, -25, 5'b01000, 2'b00, -1);
  add_case(FMT_HALF, 4'b1011, 0, 26, 3'b001, 1'b1, -26, 5'b01001, 2'b00, -1);
  add_case(FMT_BFLOAT, 4'b1011, 0, 127, 3'b001, 1'b0, -127, 5'b01000, 2'b00, 46);
  add_case(FMT_BFLOAT, 4'b1011, 0, 126, 3'b001, 1'b0, -126, 5'b00010, 2'b00, 45);
  add_case(FMT_BFLOAT, 4'b1011, 0, 133, 3'b001, 1'b0, -133, 5'b01000, 2'b00, 52);
  add_case(FMT_BFLOAT, 4'b1011, 0, 134, 3'b001, 1'b0, -134, 5'b01000, 2'b00, -1);
  add_case(FMT_BFLOAT, 4'b1011, 0, 151, 3'b001, 1'b1, -151, 5'b01001, 2'b00, -1);

  // Square root halves the difference, odd one rounds down
  add_case(FMT_DOUBLE, 4'b0111, 0, 2044, 3'b001, 1'b0, -1022, 5'b00010, 2'b00, 0);
  add_case(FMT_DOUBLE, 4'b0111, 1, 2046, 3'b001, 1'b0, -1023, 5'b00000, 2'b00, 1);
  add_case(FMT_SINGLE, 4'b0111, 0, 252, 3'b001, 1'b0, -126, 5'b00010, 2'b00, 29);
  add_case(FMT_HALF, 4'b0111, 0, 28, 3'b001, 1'b0, -14, 5'b00010, 2'b00, 42);
  add_case(FMT_BFLOAT, 4'b0111, 0, 252, 3'b001, 1'b0, -126, 5'b00010, 2'b00, 45);

  // Pipedown low holds stage three, then a new load
  add_case(FMT_HALF, 4'b1011, 20, 3, 3'b000, 1'b1, 17, 5'b10000, 2'b10, -1);
  add_case(FMT_DOUBLE, 4'b1011, 0, 1076, 3'b000, 1'b1, -1076, 5'b01001, 2'b00, -1);
  add_case(FMT_SINGLE, 4'b1011, 128, 0, 3'b001, 1'b0, 128, 5'b00100, 2'b00, -1);
endtask

`endif

// File: sim/tb_fdsu_ex2_stage.sv
//========================================
// Testbench for the divide/sqrt second
// execute stage, table driven
//========================================
`default_nettype none

module tb_fdsu_ex2_stage;

  import fdsu_pkg::*;

  // One table row of stimulus and expected values
  typedef struct packed {
    fp_fmt_t    fmt;
    logic [3:0] ctl;
    int         add0;
    int         add1;
    logic [2:0] in_bits;
    logic       skip;
    int         rst;
    logic [4:0] fl;
    logic [1:0] res;
    int         add_bit;
  } case_t;

  logic           ex2_pipe_clk;
  logic           cpurst_b;
  logic           ex2_pipedown;
  fdsu_ex2_op_t   ex2_op;
  logic           srt_ctrl_skip_srt;
  fdsu_ex3_info_t ex3_info;

  case_t           cases[$];
  fdsu_ex3_info_t  held;
  logic [RM_W-1:0] rm_v;
  logic            sign_v;
  // Pass-through bits {result_zero, result_qnan, result_inf, nv, dz}
  logic [4:0]      pass_v;
  int              idx;
  int              limit;

  fdsu_ex2_stage dut0 (
    .ex2_pipe_clk      (ex2_pipe_clk),
    .cpurst_b          (cpurst_b),
    .ex2_pipedown      (ex2_pipedown),
    .ex2_op            (ex2_op),
    .srt_ctrl_skip_srt (srt_ctrl_skip_srt),
    .ex3_info          (ex3_info)
  );

  always #2 ex2_pipe_clk = !ex2_pipe_clk;

  task automatic add_case(input fp_fmt_t fmt, input logic [3:0] ctl, input int add0,
                          input int add1, input logic [2:0] in_bits, input logic skip,
                          input int rst, input logic [4:0] fl, input logic [1:0] res,
                          input int add_bit);
    case_t c;
    c.fmt     = fmt;
    c.ctl     = ctl;
    c.add0    = add0;
    c.add1    = add1;
    c.in_bits = in_bits;
    c.skip    = skip;
    c.rst     = rst;
    c.fl      = fl;
    c.res     = res;
    c.add_bit = add_bit;
    cases.push_back(c);
  endtask

  `include "tb_fdsu_cases.svh"

  //========================================
  // Stimulus and expected value builders
  //========================================
  function automatic fdsu_ex2_op_t build_op(input case_t c, input logic [RM_W-1:0] rm,
                                            input logic sign, input logic [4:0] pass);
    fdsu_ex2_op_t op;
    op = '0;
    op.fmt = c.fmt;
    {op.div, op.sqrt, op.op0_norm, op.op1_norm} = c.ctl;
    op.expnt_add0  = 13'(c.add0);
    op.expnt_add1  = 13'(c.add1);
    op.of_rm_lfn   = c.in_bits[2];
    op.srt_skip    = c.in_bits[1];
    op.rm          = rm;
    op.result_sign = sign;
    op.result_zero = pass[4];
    op.result_qnan = pass[3];
    op.result_inf  = pass[2];
    op.nv          = pass[1];
    op.dz          = pass[0];
    return op;
  endfunction

  function automatic fdsu_ex3_info_t expect_info(input case_t c, input logic [RM_W-1:0] rm,
                                                 input logic sign, input logic [4:0] pass);
    fdsu_ex3_info_t e;
    e = '0;
    e.fmt         = c.fmt;
    e.expnt_rst   = 13'(c.rst);
    {e.of, e.uf, e.potnt_of, e.potnt_uf, e.id_srt_skip} = c.fl;
    // Denormal flag follows underflow
    e.rslt_denorm = c.fl[3];
    // Incoming infinity stays infinity
    e.result_inf  = c.res[1] || pass[2];
    e.result_lfn  = c.res[0];
    e.result_sign = sign;
    e.result_zero = pass[4];
    e.result_qnan = pass[3];
    e.nv          = pass[1];
    e.dz          = pass[0];
    e.rm          = rm;
    if (c.add_bit >= 0)
    begin
      e.denorm_round_add_num = 53'd1 << c.add_bit;
    end
    return e;
  endfunction

  //========================================
  // Compare tasks
  //========================================
  task automatic report_fail();
    $display("TESTS FAILED");
    $fatal(1, "stopping at first error");
  endtask

  task automatic check_skip(input logic got, input logic exp);
    if (got !== exp)
    begin
      $display("[FAIL] t=%0t srt_ctrl_skip_srt: got %b expected %b", $time, got, exp);
      report_fail();
    end
  endtask

  task automatic check_ex3(input fdsu_ex3_info_t got, input fdsu_ex3_info_t exp);
    if (got !== exp)
    begin
      $display("[FAIL] t=%0t ex3_info: got %h expected %h", $time, got, exp);
      report_fail();
    end
  endtask

  // Watchdog sized from the table length
  initial
  begin
    #1;
    limit = (cases.size() + 20) * 4;
    #(limit);
    $display("Watchdog expired before the case table finished");
    report_fail();
  end

  initial
  begin
    ex2_pipe_clk = 1'b0;
    cpurst_b     = 1'b0;
    ex2_pipedown = 1'b0;
    ex2_op       = '0;
    held         = '0;
    void'($urandom(79));
    load_cases();
    repeat (4) @(posedge ex2_pipe_clk);
    #1;
    cpurst_b = 1'b1;
    // Reset state before any load
    @(posedge ex2_pipe_clk);
    #1;
    check_ex3(ex3_info, held);
    for (idx = 0; idx < cases.size(); idx++)
    begin
      rm_v         = RM_W'($urandom());
      sign_v       = 1'($urandom());
      pass_v       = 5'($urandom());
      // Overflow rows keep the inf input low
      if (cases[idx].fl[4])
      begin
        pass_v[2] = 1'b0;
      end
      ex2_op       = build_op(cases[idx], rm_v, sign_v, pass_v);
      ex2_pipedown = cases[idx].in_bits[0];
      if (cases[idx].in_bits[0])
      begin
        held = expect_info(cases[idx], rm_v, sign_v, pass_v);
      end
      #1;
      check_skip(srt_ctrl_skip_srt, cases[idx].skip);
      @(posedge ex2_pipe_clk);
      #1;
      check_ex3(ex3_info, held);
    end
    $display("TESTS PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// File: sources.f
+incdir+sim
common/fdsu_pkg.sv
design/fdsu_expnt_eval.sv
design/fdsu_denorm_round_num.sv
design/fdsu_ex3_pipe.sv
design/fdsu_ex2_stage.sv
sim/tb_fdsu_ex2_stage.sv

// File: run.sh
#!/bin/sh
# Build and run the stage two testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_fdsu_ex2_stage -f sources.f \
  > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }

./obj_dir/Vtb_fdsu_ex2_stage > sim.log 2>&1
cat sim.log

grep -q "TESTS FAILED" sim.log && { echo "Simulation failed"; exit 1; } || echo "Simulation done"
